// ==== verilog/lcd_pkg.sv ====
// bus widths, cycle timing, panel command codes and the state, op and bus enums
package lcd_pkg;

    localparam int LCD_DW     = 16;
    localparam int FILL_CNT_W = 16;

    localparam int RESET_CYCLES = 16;                 // panel reset low time
    localparam int RST_CNT_W    = $clog2(RESET_CYCLES);

    localparam int WR_LOW_CYCLES  = 2;
    localparam int WR_HIGH_CYCLES = 2;
    localparam int RD_LOW_CYCLES  = 4;                // data sampled in the last low cycle
    localparam int WR_LEN         = WR_LOW_CYCLES + WR_HIGH_CYCLES;
    localparam int RD_LEN         = RD_LOW_CYCLES + 1;
    localparam int BUS_CNT_W      = $clog2((RD_LEN > WR_LEN) ? RD_LEN : WR_LEN);

    localparam int INIT_LEN = 8;
    localparam int INIT_AW  = $clog2(INIT_LEN);

    // panel commands issued by the controller itself
    localparam logic [LCD_DW-1:0] CMD_MEM_WRITE = 16'h002C;
    localparam logic [LCD_DW-1:0] CMD_READ_ID   = 16'h00D3;

    typedef enum logic [2:0] {
        OP_WR_CMD     = 3'd0,
        OP_WR_DATA    = 3'd1,
        OP_FILL_COUNT = 3'd2,
        OP_FILL       = 3'd3,
        OP_READ_ID    = 3'd4
    } host_op_t;

    typedef enum logic [2:0] {
        ST_RESET,
        ST_INIT,
        ST_IDLE,
        ST_HOST,
        ST_FILL_CMD,
        ST_FILL_PIX,
        ST_ID_CMD,
        ST_ID_READ
    } ctrl_state_t;

    typedef enum logic {
        BUS_WRITE = 1'b0,
        BUS_READ  = 1'b1
    } bus_op_t;

endpackage

// ==== verilog/lcd_init_rom.sv ====
`timescale 1ns/1ps
// panel init table: register-select flag and word per step
module lcd_init_rom (
    input  logic [lcd_pkg::INIT_AW-1:0] init_step_i,
    output logic                        init_rs_o,
    output logic [lcd_pkg::LCD_DW-1:0]  init_word_o
);

    // rs low for a command, high for one of its parameters
    always_comb begin
        case (init_step_i)
            3'd0: begin
                init_rs_o   = 1'b0;
                init_word_o = 16'h0011;     // sleep out
            end
            3'd1: begin
                init_rs_o   = 1'b0;
                init_word_o = 16'h003A;     // pixel format
            end
            3'd2: begin
                init_rs_o   = 1'b1;
                init_word_o = 16'h0055;     // 16 bits per pixel
            end
            3'd3: begin
                init_rs_o   = 1'b0;
                init_word_o = 16'h0036;     // memory access control
            end
            3'd4: begin
                init_rs_o   = 1'b1;
                init_word_o = 16'h0048;     // column order flipped, bgr
            end
            3'd5: begin
                init_rs_o   = 1'b0;
                init_word_o = 16'h0013;     // normal display mode
            end
            3'd6: begin
                init_rs_o   = 1'b0;
                init_word_o = 16'h0020;     // inversion off
            end
            3'd7: begin
                init_rs_o   = 1'b0;
                init_word_o = 16'h0029;     // display on
            end
            default: begin
                init_rs_o   = 1'b0;
                init_word_o = 16'h0000;     // nop
            end
        endcase
    end

endmodule

// ==== verilog/lcd_fill_counter.sv ====
`timescale 1ns/1ps
// pixel fill count: stored count, working down-counter and zero flag
module lcd_fill_counter (
    input  logic                             pclk,
    input  logic                             rst_n,
    input  logic                             cnt_load_i,
    input  logic [lcd_pkg::FILL_CNT_W-1:0]   cnt_value_i,
    input  logic                             cnt_dec_i,
    output logic                             cnt_zero_o
);

    logic [lcd_pkg::FILL_CNT_W-1:0] store_q;   // count from the last OP_FILL_COUNT
    logic [lcd_pkg::FILL_CNT_W-1:0] work_q;    // pixels left in this fill

    always_ff @(posedge pclk) begin
        if (!rst_n) begin
            store_q <= '0;
            work_q  <= '0;
        end else if (cnt_load_i) begin
            store_q <= cnt_value_i;
            work_q  <= cnt_value_i;
        end else if (cnt_dec_i) begin
            work_q <= work_q - 1'b1;
        end else if (work_q == '0) begin
            // drained, rearm so the next fill repeats the same count
            work_q <= store_q;
        end
    end

    // zero is seen for one cycle after the last pixel before the rearm
    assign cnt_zero_o = (work_q == '0);

    // the control must stop writing pixels once the count runs out
    a_no_dec_at_zero: assert property (@(posedge pclk) disable iff (!rst_n)
        cnt_dec_i |-> !cnt_zero_o);

endmodule

// ==== verilog/lcd_bus_writer.sv ====
`timescale 1ns/1ps
// 8080 bus cycle timing: write and read strobes, chip select, data capture
module lcd_bus_writer (
    input  logic                          pclk,
    input  logic                          rst_n,
    input  logic                          bus_start_i,
    input  lcd_pkg::bus_op_t              bus_op_i,
    input  logic                          bus_rs_i,
    input  logic [lcd_pkg::LCD_DW-1:0]    bus_wdata_i,
    input  logic [lcd_pkg::LCD_DW-1:0]    lcd_data_i,
    output logic                          bus_done_o,
    output logic [lcd_pkg::LCD_DW-1:0]    bus_rdata_o,
    output logic                          lcd_cs_o,
    output logic                          lcd_rs_o,
    output logic                          lcd_wr_o,
    output logic                          lcd_rd_o,
    output logic [lcd_pkg::LCD_DW-1:0]    lcd_data_o,
    output logic                          lcd_oe_o
);

    logic                            active;   // cycle in progress
    logic [lcd_pkg::BUS_CNT_W-1:0]   cnt;      // cycles since strobe start
    lcd_pkg::bus_op_t                op_q;
    logic                            last;

    assign last = (op_q == lcd_pkg::BUS_WRITE) ?
                  (cnt == lcd_pkg::BUS_CNT_W'(lcd_pkg::WR_LEN - 1)) :
                  (cnt == lcd_pkg::BUS_CNT_W'(lcd_pkg::RD_LEN - 1));

    assign bus_done_o = active && last;

    always_ff @(posedge pclk) begin
        if (!rst_n) begin
            active   <= 1'b0;
            cnt      <= '0;
            lcd_cs_o <= 1'b1;
            lcd_rs_o <= 1'b0;
            lcd_wr_o <= 1'b1;
            lcd_rd_o <= 1'b1;
            lcd_oe_o <= 1'b0;
        end else if (!active) begin
            if (bus_start_i) begin
                active   <= 1'b1;
                cnt      <= '0;
                lcd_cs_o <= 1'b0;
                lcd_rs_o <= bus_rs_i;
                lcd_wr_o <= (bus_op_i != lcd_pkg::BUS_WRITE);
                lcd_rd_o <= (bus_op_i != lcd_pkg::BUS_READ);
                lcd_oe_o <= (bus_op_i == lcd_pkg::BUS_WRITE);   // drive only on writes
            end
        end else begin
            cnt <= cnt + 1'b1;
            if (cnt == lcd_pkg::BUS_CNT_W'(lcd_pkg::WR_LOW_CYCLES - 1)) begin
                lcd_wr_o <= 1'b1;   // panel latches data on this edge
            end
            if (cnt == lcd_pkg::BUS_CNT_W'(lcd_pkg::RD_LOW_CYCLES - 1)) begin
                lcd_rd_o <= 1'b1;
            end
            if (last) begin
                active   <= 1'b0;
                lcd_cs_o <= 1'b1;
                lcd_oe_o <= 1'b0;
            end
        end
    end

    always_ff @(posedge pclk) begin
        if (!active && bus_start_i) begin
            op_q       <= bus_op_i;
            lcd_data_o <= bus_wdata_i;
        end
        // sample in the last low cycle of the read strobe
        if (active && op_q == lcd_pkg::BUS_READ &&
            cnt == lcd_pkg::BUS_CNT_W'(lcd_pkg::RD_LOW_CYCLES - 1)) begin
            bus_rdata_o <= lcd_data_i;
        end
    end

    a_wr_rd_exclusive: assert property (@(posedge pclk) disable iff (!rst_n)
        !(!lcd_wr_o && !lcd_rd_o));

endmodule

// ==== verilog/lcd_seq_ctrl.sv ====
`timescale 1ns/1ps
// control FSM: panel reset delay, init playback, host ops, pixel fill and ID read
module lcd_seq_ctrl (
    input  logic                              pclk,
    input  logic                              rst_n,
    input  logic                              cmd_valid_i,
    input  lcd_pkg::host_op_t                 cmd_op_i,
    input  logic [lcd_pkg::LCD_DW-1:0]        cmd_data_i,
    input  logic                              init_rs_i,
    input  logic [lcd_pkg::LCD_DW-1:0]        init_word_i,
    input  logic                              cnt_zero_i,
    input  logic                              bus_done_i,
    input  logic [lcd_pkg::LCD_DW-1:0]        bus_rdata_i,
    output logic                              busy_o,
    output logic [lcd_pkg::LCD_DW-1:0]        rd_data_o,
    output logic                              rd_valid_o,
    output logic                              lcd_rst_o,
    output logic                              lcd_bl_o,
    output logic [lcd_pkg::INIT_AW-1:0]       init_step_o,
    output logic                              cnt_load_o,
    output logic [lcd_pkg::FILL_CNT_W-1:0]    cnt_value_o,
    output logic                              cnt_dec_o,
    output logic                              bus_start_o,
    output lcd_pkg::bus_op_t                  bus_op_o,
    output logic                              bus_rs_o,
    output logic [lcd_pkg::LCD_DW-1:0]        bus_wdata_o
);

    lcd_pkg::ctrl_state_t            state;
    logic [lcd_pkg::RST_CNT_W-1:0]   rst_cnt;
    logic [lcd_pkg::LCD_DW-1:0]      color_q;    // fill color
    logic                            pend;       // writer cycle open
    logic                            id_dummy;   // first read after READ_ID is thrown away
    logic                            bus_free;

    assign busy_o    = (state != lcd_pkg::ST_IDLE);
    assign bus_free  = !pend && !bus_start_o;
    assign cnt_dec_o = (state == lcd_pkg::ST_FILL_PIX) && bus_done_i;   // one per pixel

    task automatic issue(input lcd_pkg::bus_op_t op, input logic rs,
                         input logic [lcd_pkg::LCD_DW-1:0] word);
        bus_start_o <= 1'b1;
        bus_op_o    <= op;
        bus_rs_o    <= rs;
        bus_wdata_o <= word;
    endtask

    always_ff @(posedge pclk) begin
        bus_start_o <= 1'b0;
        cnt_load_o  <= 1'b0;
        rd_valid_o  <= 1'b0;
        if (!rst_n) begin
            state       <= lcd_pkg::ST_RESET;
            rst_cnt     <= '0;
            init_step_o <= '0;
            pend        <= 1'b0;
            id_dummy    <= 1'b0;
            lcd_rst_o   <= 1'b0;
            lcd_bl_o    <= 1'b0;
        end else begin
            if (bus_start_o) begin
                pend <= 1'b1;
            end else if (bus_done_i) begin
                pend <= 1'b0;
            end
            case (state)
                lcd_pkg::ST_RESET: begin
                    if (rst_cnt == lcd_pkg::RST_CNT_W'(lcd_pkg::RESET_CYCLES - 1)) begin
                        lcd_rst_o <= 1'b1;
                        state     <= lcd_pkg::ST_INIT;
                    end else begin
                        rst_cnt <= rst_cnt + 1'b1;
                    end
                end
                lcd_pkg::ST_INIT: begin
                    if (bus_done_i) begin
                        if (init_step_o == lcd_pkg::INIT_AW'(lcd_pkg::INIT_LEN - 1)) begin
                            lcd_bl_o <= 1'b1;       // table done, backlight on
                            state    <= lcd_pkg::ST_IDLE;
                        end else begin
                            init_step_o <= init_step_o + 1'b1;
                        end
                    end else if (bus_free) begin
                        issue(lcd_pkg::BUS_WRITE, init_rs_i, init_word_i);
                    end
                end
                lcd_pkg::ST_IDLE: begin
                    if (cmd_valid_i) begin
                        case (cmd_op_i)
                            lcd_pkg::OP_WR_CMD, lcd_pkg::OP_WR_DATA: begin
                                issue(lcd_pkg::BUS_WRITE, cmd_op_i == lcd_pkg::OP_WR_DATA,
                                      cmd_data_i);
                                state <= lcd_pkg::ST_HOST;
                            end
                            lcd_pkg::OP_FILL_COUNT: begin
                                cnt_load_o  <= 1'b1;
                                cnt_value_o <= cmd_data_i;
                                state       <= lcd_pkg::ST_HOST;
                            end
                            lcd_pkg::OP_FILL: begin
                                color_q <= cmd_data_i;
                                issue(lcd_pkg::BUS_WRITE, 1'b0, lcd_pkg::CMD_MEM_WRITE);
                                state   <= lcd_pkg::ST_FILL_CMD;
                            end
                            lcd_pkg::OP_READ_ID: begin
                                issue(lcd_pkg::BUS_WRITE, 1'b0, lcd_pkg::CMD_READ_ID);
                                state <= lcd_pkg::ST_ID_CMD;
                            end
                            default: state <= lcd_pkg::ST_IDLE;   // unknown op dropped
                        endcase
                    end
                end
                lcd_pkg::ST_HOST: begin
                    if (bus_free) begin
                        state <= lcd_pkg::ST_IDLE;
                    end
                end
                lcd_pkg::ST_FILL_CMD: begin
                    if (bus_done_i) begin
                        if (cnt_zero_i) begin
                            state <= lcd_pkg::ST_IDLE;   // empty fill writes only the command
                        end else begin
                            issue(lcd_pkg::BUS_WRITE, 1'b1, color_q);
                            state <= lcd_pkg::ST_FILL_PIX;
                        end
                    end
                end
                lcd_pkg::ST_FILL_PIX: begin
                    // counter has taken the decrement by the time the bus is free
                    if (bus_free) begin
                        if (cnt_zero_i) begin
                            state <= lcd_pkg::ST_IDLE;
                        end else begin
                            issue(lcd_pkg::BUS_WRITE, 1'b1, color_q);
                        end
                    end
                end
                lcd_pkg::ST_ID_CMD: begin
                    if (bus_free) begin
                        issue(lcd_pkg::BUS_READ, 1'b1, '0);
                        id_dummy <= 1'b1;
                        state    <= lcd_pkg::ST_ID_READ;
                    end
                end
                lcd_pkg::ST_ID_READ: begin
                    if (bus_done_i) begin
                        if (id_dummy) begin
                            id_dummy <= 1'b0;
                        end else begin
                            rd_data_o  <= bus_rdata_i;
                            rd_valid_o <= 1'b1;
                            state      <= lcd_pkg::ST_IDLE;
                        end
                    end else if (bus_free) begin
                        issue(lcd_pkg::BUS_READ, 1'b1, '0);   // the real ID word
                    end
                end
                default: state <= lcd_pkg::ST_IDLE;
            endcase
        end
    end

    // start only once the writer has closed the previous cycle
    a_start_after_done: assert property (@(posedge pclk) disable iff (!rst_n)
        bus_start_o |-> !pend);

    // a command during a busy state starts nothing and latches nothing
    a_busy_cmd_dropped: assert property (@(posedge pclk) disable iff (!rst_n)
        (cmd_valid_i && busy_o) |=> ($stable(color_q) && !cnt_load_o &&
            (state == $past(state) ||
             !(state inside {lcd_pkg::ST_HOST, lcd_pkg::ST_FILL_CMD, lcd_pkg::ST_ID_CMD}))));

endmodule

// ==== verilog/lcd_top.sv ====
`timescale 1ns/1ps
// lcd controller top: control FSM, init table, fill counter, bus timing, tristate data bus
module lcd_top (
    input  logic                             pclk,
    input  logic                             rst_n,
    input  logic                             cmd_valid_i,
    input  lcd_pkg::host_op_t                cmd_op_i,
    input  logic [lcd_pkg::LCD_DW-1:0]       cmd_data_i,
    output logic                             busy_o,
    output logic [lcd_pkg::LCD_DW-1:0]       rd_data_o,
    output logic                             rd_valid_o,
    output logic                             lcd_rst_o,
    output logic                             lcd_cs_o,
    output logic                             lcd_rs_o,
    output logic                             lcd_wr_o,
    output logic                             lcd_rd_o,
    output logic                             lcd_bl_o,
    inout  wire  [lcd_pkg::LCD_DW-1:0]       lcd_data_io
);

    logic [lcd_pkg::INIT_AW-1:0]     init_step;
    logic                            init_rs;
    logic [lcd_pkg::LCD_DW-1:0]      init_word;
    logic                            cnt_load;
    logic [lcd_pkg::FILL_CNT_W-1:0]  cnt_value;
    logic                            cnt_dec;
    logic                            cnt_zero;
    logic                            bus_start;
    lcd_pkg::bus_op_t                bus_op;
    logic                            bus_rs;
    logic [lcd_pkg::LCD_DW-1:0]      bus_wdata;
    logic                            bus_done;
    logic [lcd_pkg::LCD_DW-1:0]      bus_rdata;
    logic [lcd_pkg::LCD_DW-1:0]      lcd_wdata;
    logic                            lcd_oe;

    // panel drives the pins whenever the writer releases them
    assign lcd_data_io = lcd_oe ? lcd_wdata : {lcd_pkg::LCD_DW{1'bz}};

    lcd_seq_ctrl u_seq_ctrl (
        .pclk        (pclk),
        .rst_n       (rst_n),
        .cmd_valid_i (cmd_valid_i),
        .cmd_op_i    (cmd_op_i),
        .cmd_data_i  (cmd_data_i),
        .init_rs_i   (init_rs),
        .init_word_i (init_word),
        .cnt_zero_i  (cnt_zero),
        .bus_done_i  (bus_done),
        .bus_rdata_i (bus_rdata),
        .busy_o      (busy_o),
        .rd_data_o   (rd_data_o),
        .rd_valid_o  (rd_valid_o),
        .lcd_rst_o   (lcd_rst_o),
        .lcd_bl_o    (lcd_bl_o),
        .init_step_o (init_step),
        .cnt_load_o  (cnt_load),
        .cnt_value_o (cnt_value),
        .cnt_dec_o   (cnt_dec),
        .bus_start_o (bus_start),
        .bus_op_o    (bus_op),
        .bus_rs_o    (bus_rs),
        .bus_wdata_o (bus_wdata)
    );

    lcd_init_rom u_init_rom (
        .init_step_i (init_step),
        .init_rs_o   (init_rs),
        .init_word_o (init_word)
    );

    lcd_fill_counter u_fill_counter (
        .pclk        (pclk),
        .rst_n       (rst_n),
        .cnt_load_i  (cnt_load),
        .cnt_value_i (cnt_value),
        .cnt_dec_i   (cnt_dec),
        .cnt_zero_o  (cnt_zero)
    );

    lcd_bus_writer u_bus_writer (
        .pclk        (pclk),
        .rst_n       (rst_n),
        .bus_start_i (bus_start),
        .bus_op_i    (bus_op),
        .bus_rs_i    (bus_rs),
        .bus_wdata_i (bus_wdata),
        .lcd_data_i  (lcd_data_io),
        .bus_done_o  (bus_done),
        .bus_rdata_o (bus_rdata),
        .lcd_cs_o    (lcd_cs_o),
        .lcd_rs_o    (lcd_rs_o),
        .lcd_wr_o    (lcd_wr_o),
        .lcd_rd_o    (lcd_rd_o),
        .lcd_data_o  (lcd_wdata),
        .lcd_oe_o    (lcd_oe)
    );

endmodule

// ==== test/lcd_tb.sv ====
`timescale 1ns/1ps
// testbench for lcd_top: clock, reset, panel bus model, directed tests and checks
module lcd_tb;

    localparam logic [lcd_pkg::LCD_DW-1:0] PANEL_ID = 16'h9341;
    localparam int TIMEOUT = 1000;          // cycles per wait

    logic                          pclk;
    logic                          rst_n;
    logic                          cmd_valid_i;
    lcd_pkg::host_op_t             cmd_op_i;
    logic [lcd_pkg::LCD_DW-1:0]    cmd_data_i;
    logic                          busy_o;
    logic [lcd_pkg::LCD_DW-1:0]    rd_data_o;
    logic                          rd_valid_o;
    logic                          lcd_rst_o;
    logic                          lcd_cs_o;
    logic                          lcd_rs_o;
    logic                          lcd_wr_o;
    logic                          lcd_rd_o;
    logic                          lcd_bl_o;
    wire  [lcd_pkg::LCD_DW-1:0]    lcd_data_io;

    logic [lcd_pkg::LCD_DW:0]      cap_q[$];     // {rs, word} per panel write
    logic [lcd_pkg::LCD_DW:0]      exp_q[$];
    logic                          wr_prev = 1'b1;
    int                            rd_valid_cnt = 0;
    int                            value_errs = 0;
    int                            other_errs = 0;
    logic [31:0]                   lfsr_q = 32'hff20;

    lcd_top dut_i (
        .pclk        (pclk),
        .rst_n       (rst_n),
        .cmd_valid_i (cmd_valid_i),
        .cmd_op_i    (cmd_op_i),
        .cmd_data_i  (cmd_data_i),
        .busy_o      (busy_o),
        .rd_data_o   (rd_data_o),
        .rd_valid_o  (rd_valid_o),
        .lcd_rst_o   (lcd_rst_o),
        .lcd_cs_o    (lcd_cs_o),
        .lcd_rs_o    (lcd_rs_o),
        .lcd_wr_o    (lcd_wr_o),
        .lcd_rd_o    (lcd_rd_o),
        .lcd_bl_o    (lcd_bl_o),
        .lcd_data_io (lcd_data_io)
    );

    always #5 pclk = ~pclk;

    // panel answers with its ID while the read strobe is low
    assign lcd_data_io = !lcd_rd_o ? PANEL_ID : {lcd_pkg::LCD_DW{1'bz}};

    // panel model: latch rs and data on the rising write strobe
    always @(posedge pclk) begin
        wr_prev <= lcd_wr_o;
        if (wr_prev === 1'b0 && lcd_wr_o === 1'b1 && lcd_cs_o === 1'b0) begin
            cap_q.push_back({lcd_rs_o, lcd_data_io});
        end
        if (rd_valid_o === 1'b1) begin
            rd_valid_cnt <= rd_valid_cnt + 1;
        end
    end

    // galois lfsr, one step per bit taken
    function automatic logic [31:0] rand_bits(input int n);
        logic [31:0] r;
        r = '0;
        for (int i = 0; i < n; i++) begin
            r     = {r[30:0], lfsr_q[0]};
            lfsr_q = lfsr_q[0] ? ((lfsr_q >> 1) ^ 32'hA3000000) : (lfsr_q >> 1);
        end
        return r;
    endfunction

    task automatic check_word(input string name, input logic [lcd_pkg::LCD_DW-1:0] got,
                              input logic [lcd_pkg::LCD_DW-1:0] exp);
        if (got !== exp) begin
            $display("ERROR at %0t: %s = %h, expected %h", $time, name, got, exp);
            value_errs++;
        end
    endtask

    task automatic check_bit(input string name, input logic got, input logic exp);
        if (got !== exp) begin
            $display("ERROR at %0t: %s = %b, expected %b", $time, name, got, exp);
            value_errs++;
        end
    endtask

    task automatic note_failure(input string what);
        $display("FAILURE at %0t: %s", $time, what);
        other_errs++;
    endtask

    // call on a rising edge; the DUT sees the op on the next one
    task automatic send_cmd(input lcd_pkg::host_op_t op,
                            input logic [lcd_pkg::LCD_DW-1:0] data);
        cmd_valid_i <= 1'b1;
        cmd_op_i    <= op;
        cmd_data_i  <= data;
        @(posedge pclk);
        cmd_valid_i <= 1'b0;
    endtask

    task automatic wait_idle(input string what);
        int n;
        n = 0;
        @(posedge pclk);
        while (busy_o !== 1'b0 && n < TIMEOUT) begin
            @(posedge pclk);
            n++;
        end
        if (busy_o !== 1'b0) note_failure({what, ": busy_o never fell"});
    endtask

    task automatic wait_rd_valid();
        int n;
        n = 0;
        @(posedge pclk);
        while (rd_valid_o !== 1'b1 && n < TIMEOUT) begin
            @(posedge pclk);
            n++;
        end
        if (rd_valid_o !== 1'b1) note_failure("read ID: rd_valid_o never pulsed");
    endtask

    task automatic expect_write(input logic rs, input logic [lcd_pkg::LCD_DW-1:0] word);
        exp_q.push_back({rs, word});
    endtask

    // compare panel writes captured since base with the expected list
    task automatic compare_writes(input int base, input string what);
        int got_n;
        got_n = cap_q.size() - base;
        if (got_n != exp_q.size()) begin
            note_failure($sformatf("%s: %0d panel writes seen, %0d expected",
                                   what, got_n, exp_q.size()));
        end
        for (int i = 0; i < exp_q.size() && i < got_n; i++) begin
            check_bit("lcd_rs_o", cap_q[base+i][lcd_pkg::LCD_DW], exp_q[i][lcd_pkg::LCD_DW]);
            check_word("lcd_data_io", cap_q[base+i][lcd_pkg::LCD_DW-1:0],
                       exp_q[i][lcd_pkg::LCD_DW-1:0]);
        end
        exp_q.delete();
    endtask

    task automatic test_reset_init();
        int base;
        base = cap_q.size();
        repeat (lcd_pkg::RESET_CYCLES) begin
            @(posedge pclk);
            check_bit("lcd_rst_o", lcd_rst_o, 1'b0);
            check_bit("lcd_cs_o", lcd_cs_o, 1'b1);
            check_bit("lcd_wr_o", lcd_wr_o, 1'b1);
            check_bit("lcd_rd_o", lcd_rd_o, 1'b1);
            check_bit("lcd_bl_o", lcd_bl_o, 1'b0);
            check_bit("busy_o", busy_o, 1'b1);
            check_bit("rd_valid_o", rd_valid_o, 1'b0);
        end
        wait_idle("init");
        expect_write(1'b0, 16'h0011);    // sleep out
        expect_write(1'b0, 16'h003A);
        expect_write(1'b1, 16'h0055);    // 16 bpp
        expect_write(1'b0, 16'h0036);
        expect_write(1'b1, 16'h0048);
        expect_write(1'b0, 16'h0013);
        expect_write(1'b0, 16'h0020);
        expect_write(1'b0, 16'h0029);    // display on
        compare_writes(base, "init table");
        check_bit("lcd_rst_o", lcd_rst_o, 1'b1);
        check_bit("lcd_bl_o", lcd_bl_o, 1'b1);
    endtask

    task automatic test_host_write(input lcd_pkg::host_op_t op, input logic rs);
        int base;
        logic [lcd_pkg::LCD_DW-1:0] w;
        base = cap_q.size();
        w    = lcd_pkg::LCD_DW'(rand_bits(16));
        send_cmd(op, w);
        wait_idle("host write");
        expect_write(rs, w);
        compare_writes(base, "host write");
    endtask

    task automatic load_count(input logic [lcd_pkg::FILL_CNT_W-1:0] n);
        send_cmd(lcd_pkg::OP_FILL_COUNT, n);
        wait_idle("fill count");
    endtask

    task automatic test_fill();
        int base;
        logic [lcd_pkg::FILL_CNT_W-1:0] n;
        logic [lcd_pkg::LCD_DW-1:0] color;
        n     = lcd_pkg::FILL_CNT_W'(rand_bits(4));
        color = lcd_pkg::LCD_DW'(rand_bits(16));
        load_count(n);
        base = cap_q.size();
        send_cmd(lcd_pkg::OP_FILL, color);
        wait_idle("fill");
        expect_write(1'b0, lcd_pkg::CMD_MEM_WRITE);
        repeat (n) expect_write(1'b1, color);
        compare_writes(base, $sformatf("fill of %0d pixels", n));
    endtask

    task automatic test_read_id();
        int base;
        int pulses;
        base   = cap_q.size();
        pulses = rd_valid_cnt;
        send_cmd(lcd_pkg::OP_READ_ID, '0);
        wait_rd_valid();
        check_word("rd_data_o", rd_data_o, PANEL_ID);
        wait_idle("read ID");
        repeat (4) @(posedge pclk);
        if (rd_valid_cnt - pulses != 1) begin
            note_failure($sformatf("read ID gave %0d rd_valid_o pulses", rd_valid_cnt - pulses));
        end
        expect_write(1'b0, lcd_pkg::CMD_READ_ID);
        compare_writes(base, "read ID");
    endtask

    // a write command sent mid-fill must be dropped
    task automatic test_busy_drop();
        int base;
        logic [lcd_pkg::FILL_CNT_W-1:0] n;
        logic [lcd_pkg::LCD_DW-1:0] color;
        n     = lcd_pkg::FILL_CNT_W'(4 + rand_bits(3));   // long enough to stay busy
        color = lcd_pkg::LCD_DW'(rand_bits(16));
        load_count(n);
        base = cap_q.size();
        send_cmd(lcd_pkg::OP_FILL, color);
        repeat (3) @(posedge pclk);
        check_bit("busy_o", busy_o, 1'b1);
        send_cmd(lcd_pkg::OP_WR_CMD, ~color);
        wait_idle("fill with dropped command");
        repeat (10) @(posedge pclk);
        expect_write(1'b0, lcd_pkg::CMD_MEM_WRITE);
        repeat (n) expect_write(1'b1, color);
        compare_writes(base, "fill with dropped command");
    endtask

    initial begin
        pclk        = 1'b0;
        rst_n       = 1'b0;
        cmd_valid_i = 1'b0;
        cmd_op_i    = lcd_pkg::OP_WR_CMD;
        cmd_data_i  = '0;
        repeat (8) @(posedge pclk);
        rst_n <= 1'b1;
        test_reset_init();
        test_host_write(lcd_pkg::OP_WR_CMD, 1'b0);
        test_host_write(lcd_pkg::OP_WR_DATA, 1'b1);
        test_fill();
        test_fill();
        test_read_id();
        test_busy_drop();
        $display("run done: %0d value errors, %0d other failures", value_errs, other_errs);
        if (value_errs == 0 && other_errs == 0) begin
            $display("Testbench passed");
        end else begin
            $display("Testbench failed");
        end
        $finish;
    end

endmodule

// ==== lcd_panel.f ====
verilog/lcd_pkg.sv
verilog/lcd_init_rom.sv
verilog/lcd_fill_counter.sv
verilog/lcd_bus_writer.sv
verilog/lcd_seq_ctrl.sv
verilog/lcd_top.sv
test/lcd_tb.sv

// ==== Makefile ====
# Verilator build and run of the lcd panel controller testbench

SRCS := $(shell cat lcd_panel.f)

.PHONY: all run clean

all: run

obj_dir/Vlcd_tb: lcd_panel.f $(SRCS)
	verilator --binary --timing --assert -Wno-fatal --top-module lcd_tb -f lcd_panel.f

run: obj_dir/Vlcd_tb
	./obj_dir/Vlcd_tb | tee sim.log
	@if grep -q "Testbench failed" sim.log; then exit 1; fi
	@grep -q "Testbench passed" sim.log

clean:
	rm -rf obj_dir sim.log
